//--- dv/io_testdata.txt
# W addr data | R addr expected | I bank pattern | O bank expected gpo (all hex)
# bank A registers at ff22/ff23, bank B at ff24/ff25
O a 0
O b 0
R ff22 00
R ff23 00
R ff24 00
R ff25 00
# input bits 0, 5 and 127 on bank A, bit 10 on bank B
I a 80000000000000000000000000000021
W ff22 05
R ff22 05
R ff23 01
W ff22 06
R ff23 00
W ff22 7f
R ff23 01
W ff22 80
R ff23 00
I b 00000000000000000000000000000400
W ff24 0a
R ff24 0a
R ff25 01
R ff22 80
# bank A output edits
W ff22 03
R ff23 00
W ff23 0c
O a 8
O b 0
R ff23 06
W ff22 05
R ff23 05
W ff23 0c
O a 28
R ff23 07
W ff22 03
W ff23 08
O a 20
R ff23 00
W ff22 7f
W ff23 0c
O a 80000000000000000000000000000020
R ff23 07
W ff23 f4
R ff23 04
# bank B output edits
W ff25 0c
O b 400
O a 80000000000000000000000000000020
R ff25 07
W ff24 40
W ff25 0c
O b 00000000000000010000000000000400
R ff25 06
# outside both windows
R ff21 00
R ff26 00
R 0000 00
W ff26 ff
W ff21 0c
W 0022 05
O a 80000000000000000000000000000020
O b 00000000000000010000000000000400
R ff22 7f
R ff23 04
R ff24 40
R ff25 06

//--- reflet_io_subsystem.f
source/reflet_io_pkg.sv
source/reflet_addressable_io.sv
source/reflet_extended_io.sv
source/reflet_bus_port.sv
source/reflet_io_subsystem.sv
dv/reflet_io_subsystem_tb.sv

//--- Makefile
TOP := reflet_io_subsystem_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f reflet_io_subsystem.f -o $(TOP)
	-./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation did not finish"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- dv/reflet_io_subsystem_tb.sv
`timescale 1ns/100ps

module reflet_io_subsystem_tb;
    import reflet_io_pkg::*;

    localparam logic [bus_addr_size-1:0] base_addr = 16'hFF22;
    localparam int number_of_io = 128;

    logic                     clk;
    logic                     reset;
    logic                     enable;
    logic [bus_addr_size-1:0] addr;
    logic                     write_en;
    logic [bus_width-1:0]     data_in;
    logic [bus_width-1:0]     data_out;
    logic [number_of_io-1:0]  gpi_a;
    logic [number_of_io-1:0]  gpi_b;
    logic [number_of_io-1:0]  gpo_a;
    logic [number_of_io-1:0]  gpo_b;

    // one entry per data line with kind letter, address or bank and value
    logic [7:0]               kind_q[$];
    logic [bus_addr_size-1:0] field_q[$];
    logic [number_of_io-1:0]  value_q[$];

    int cycles = 0;
    int cycle_limit = 0;

    reflet_io_subsystem #(
        .base_addr    (base_addr),
        .number_of_io (number_of_io)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (data_out),
        .gpi_a    (gpi_a),
        .gpi_b    (gpi_b),
        .gpo_a    (gpo_a),
        .gpo_b    (gpo_b)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    // limit is zero until the data file is loaded
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("test timed out after %0d cycles", cycles);
            abort_run();
        end
    end

    task automatic load_test_data();
        int                      fd;
        int                      n;
        string                   line;
        logic [7:0]              kind;
        logic [bus_addr_size-1:0] field;
        logic [number_of_io-1:0] value;
        fd = $fopen("dv/io_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test data file dv/io_testdata.txt");
            abort_run();
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 2)
            begin
                kind = line.getc(0);
                // skip comment lines
                if (kind != "#")
                begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h", field, value);
                    if (n != 2)
                    begin
                        $display("malformed test data line: %s", line);
                        abort_run();
                    end
                    kind_q.push_back(kind);
                    field_q.push_back(field);
                    value_q.push_back(value);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic bus_write(
        input logic [bus_addr_size-1:0] a,
        input logic [bus_width-1:0]     d
    );
        @(posedge clk);
        enable   <= 1'b1;
        addr     <= a;
        write_en <= 1'b1;
        data_in  <= d;
        @(posedge clk);
        enable   <= 1'b0;
        write_en <= 1'b0;
        // status and outputs settle within four cycles
        repeat (4) @(posedge clk);
    endtask

    task automatic bus_read(
        input logic [bus_addr_size-1:0] a,
        input logic [bus_width-1:0]     exp
    );
        @(posedge clk);
        enable   <= 1'b1;
        addr     <= a;
        write_en <= 1'b0;
        @(posedge clk);
        enable   <= 1'b0;
        // request register and data_out register each take an edge
        @(posedge clk);
        @(negedge clk);
        assert (data_out === exp)
        else
        begin
            $display("Error: data_out at address %h is %h, expected %h", a, data_out, exp);
            abort_run();
        end
    endtask

    task automatic drive_gpi(
        input logic [bus_addr_size-1:0] bank,
        input logic [number_of_io-1:0]  p
    );
        @(posedge clk);
        if (bank == 16'h000a)
        begin
            gpi_a <= p;
        end
        else
        begin
            gpi_b <= p;
        end
    endtask

    task automatic check_gpo(
        input logic [bus_addr_size-1:0] bank,
        input logic [number_of_io-1:0]  exp
    );
        @(negedge clk);
        if (bank == 16'h000a)
        begin
            assert (gpo_a === exp)
            else
            begin
                $display("Error: gpo_a is %h, expected %h", gpo_a, exp);
                abort_run();
            end
        end
        else
        begin
            assert (gpo_b === exp)
            else
            begin
                $display("Error: gpo_b is %h, expected %h", gpo_b, exp);
                abort_run();
            end
        end
    endtask

    initial
    begin
        reset    = 1'b0;
        enable   = 1'b0;
        addr     = '0;
        write_en = 1'b0;
        data_in  = '0;
        gpi_a    = '0;
        gpi_b    = '0;
        load_test_data();
        cycle_limit = 8 * kind_q.size() + 100;
        // reset value reaches data_out at the first edge
        @(posedge clk);
        @(negedge clk);
        assert (data_out === '0)
        else
        begin
            $display("Error: data_out in reset is %h, expected %h", data_out, 8'h00);
            abort_run();
        end
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < kind_q.size(); i++)
        begin
            case (kind_q[i])
                "W": bus_write(field_q[i], value_q[i][bus_width-1:0]);
                "R": bus_read(field_q[i], value_q[i][bus_width-1:0]);
                "I": drive_gpi(field_q[i], value_q[i]);
                "O": check_gpo(field_q[i], value_q[i]);
                default:
                begin
                    $display("unknown line kind in test data entry %0d", i);
                    abort_run();
                end
            endcase
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- source/reflet_io_subsystem.sv
`timescale 1ns/100ps

module reflet_io_subsystem #(
    parameter logic [reflet_io_pkg::bus_addr_size-1:0] base_addr = 16'hFF22,
    parameter int number_of_io = 128
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     enable,
    input  logic [reflet_io_pkg::bus_addr_size-1:0]  addr,
    input  logic                                     write_en,
    input  logic [reflet_io_pkg::bus_width-1:0]      data_in,
    output logic [reflet_io_pkg::bus_width-1:0]      data_out,
    input  logic [number_of_io-1:0]                  gpi_a,
    input  logic [number_of_io-1:0]                  gpi_b,
    output logic [number_of_io-1:0]                  gpo_a,
    output logic [number_of_io-1:0]                  gpo_b
);
    import reflet_io_pkg::*;

    bus_request_t  request;
    bus_response_t response_a;
    bus_response_t response_b;

    reflet_bus_port bus_port (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .addr       (addr),
        .write_en   (write_en),
        .data_in    (data_in),
        .data_out   (data_out),
        .request    (request),
        .response_a (response_a),
        .response_b (response_b)
    );

    // bank a at base_addr
    reflet_extended_io #(
        .base_addr    (base_addr),
        .number_of_io (number_of_io)
    ) bank_a (
        .clk      (clk),
        .reset    (reset),
        .request  (request),
        .response (response_a),
        .gpi      (gpi_a),
        .gpo      (gpo_a)
    );

    // bank b right after the two registers of bank a
    reflet_extended_io #(
        .base_addr    (base_addr + bus_addr_size'(2)),
        .number_of_io (number_of_io)
    ) bank_b (
        .clk      (clk),
        .reset    (reset),
        .request  (request),
        .response (response_b),
        .gpi      (gpi_b),
        .gpo      (gpo_b)
    );

endmodule

//--- source/reflet_bus_port.sv
`timescale 1ns/100ps

module reflet_bus_port (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     enable,
    input  logic [reflet_io_pkg::bus_addr_size-1:0]  addr,
    input  logic                                     write_en,
    input  logic [reflet_io_pkg::bus_width-1:0]      data_in,
    output logic [reflet_io_pkg::bus_width-1:0]      data_out,
    output reflet_io_pkg::bus_request_t              request,
    input  reflet_io_pkg::bus_response_t             response_a,
    input  reflet_io_pkg::bus_response_t             response_b
);
    import reflet_io_pkg::*;

    logic [bus_width-1:0] merged_data;
    logic                 busy_a;
    logic                 busy_b;

    // the valid bit marks a one-cycle access
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            request.valid <= 1'b0;
        end
        else
        begin
            request.valid <= enable;
        end
    end

    // address and data only matter while valid
    always_ff @(posedge clk)
    begin
        request.addr     <= addr;
        request.write_en <= write_en;
        request.data     <= data_in;
    end

    // banks drive zero when idle, so OR is enough
    assign merged_data = response_a.data | response_b.data;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            data_out <= '0;
        end
        else
        begin
            data_out <= merged_data;
        end
    end

    assign busy_a = |response_a.data;
    assign busy_b = |response_b.data;

    // overlapping bank windows would corrupt the merged read
    one_responder_a: assert property (
        @(posedge clk) disable iff (!reset)
        !(busy_a && busy_b)
    ) else $error("both banks answered address %h", request.addr);

endmodule

//--- source/reflet_extended_io.sv
`timescale 1ns/100ps

module reflet_extended_io #(
    parameter logic [reflet_io_pkg::bus_addr_size-1:0] base_addr = 16'hFF22,
    parameter int number_of_io = 128
) (
    input  logic                          clk,
    input  logic                          reset,
    input  reflet_io_pkg::bus_request_t   request,
    output reflet_io_pkg::bus_response_t  response,
    input  logic [number_of_io-1:0]       gpi,
    output logic [number_of_io-1:0]       gpo
);
    import reflet_io_pkg::*;

    // window decode
    logic [bus_addr_size-1:0] offset;
    logic                     hit;
    logic                     sel_addr;
    logic                     sel_ctrl;

    // bank registers
    logic [io_addr_size-1:0]  io_addr;
    logic [bus_width-1:0]     io_ctrl;

    // status refresh tracking
    logic [io_addr_size-1:0]  io_addr_prev;
    logic                     refresh_delay;
    logic                     addr_changed;
    logic                     refresh;
    logic [bus_width-1:0]     status_word;

    // addressable io hookup
    logic                     gpi_read;
    logic                     gpo_read;
    logic                     gpo_write;
    logic                     edit_gpo;

    assign offset   = request.addr - base_addr;
    assign sel_addr = offset == reg_io_addr;
    assign sel_ctrl = offset == reg_io_ctrl;
    assign hit      = request.valid && (sel_addr || sel_ctrl);

    assign gpo_write = io_ctrl[ctrl_gpo_write];
    assign edit_gpo  = io_ctrl[ctrl_edit_gpo];

    // fresh status, strobe cleared, write value kept
    always_comb
    begin
        status_word = '0;
        status_word[ctrl_gpi_read]  = gpi_read;
        status_word[ctrl_gpo_read]  = gpo_read;
        status_word[ctrl_gpo_write] = gpo_write;
        status_word[ctrl_edit_gpo]  = 1'b0;
    end

    assign addr_changed = io_addr != io_addr_prev;
    assign refresh      = addr_changed || edit_gpo || refresh_delay;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            io_addr <= '0;
        end
        else if (hit && request.write_en && sel_addr)
        begin
            io_addr <= request.data;
        end
    end

    // bus write wins over a refresh in the same cycle
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            io_ctrl <= '0;
        end
        else if (hit && request.write_en && sel_ctrl)
        begin
            io_ctrl <= request.data & ctrl_mask;
        end
        else if (refresh)
        begin
            io_ctrl <= status_word;
        end
    end

    // second refresh after an edit picks up the new output value;
    // starting at 1 gives one refresh right after reset
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            io_addr_prev  <= '0;
            refresh_delay <= 1'b1;
        end
        else
        begin
            io_addr_prev  <= io_addr;
            refresh_delay <= edit_gpo;
        end
    end

    // read data, zero unless a read of this window
    always_comb
    begin
        response.data = '0;
        if (hit && !request.write_en)
        begin
            if (sel_addr)
            begin
                response.data = io_addr;
            end
            else
            begin
                response.data = io_ctrl;
            end
        end
    end

    reflet_addressable_io #(
        .number_of_io (number_of_io)
    ) io (
        .clk       (clk),
        .reset     (reset),
        .io_addr   (io_addr),
        .gpi_read  (gpi_read),
        .gpo_read  (gpo_read),
        .gpo_write (gpo_write),
        .edit_gpo  (edit_gpo),
        .gpi       (gpi),
        .gpo       (gpo)
    );

    // strobe is self-clearing unless the master ignores the idle rule
    edit_single_cycle_a: assert property (
        @(posedge clk) disable iff (!reset)
        edit_gpo |=> !edit_gpo
    ) else $error("edit strobe held for two cycles at bank %h", base_addr);

endmodule

//--- source/reflet_addressable_io.sv
`timescale 1ns/100ps

module reflet_addressable_io #(
    parameter int number_of_io = 128
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [reflet_io_pkg::io_addr_size-1:0]  io_addr,
    output logic                                    gpi_read,
    output logic                                    gpo_read,
    input  logic                                    gpo_write,
    input  logic                                    edit_gpo,
    input  logic [number_of_io-1:0]                 gpi,
    output logic [number_of_io-1:0]                 gpo
);
    import reflet_io_pkg::*;

    // zero-extended copies so any byte address is a legal index
    logic [max_io-1:0] gpi_wide;
    logic [max_io-1:0] gpo_wide;
    logic              in_range;

    assign gpi_wide = max_io'(gpi);
    assign gpo_wide = max_io'(gpo);
    assign in_range = int'(io_addr) < number_of_io;

    // status of the selected bit, out of range reads zero
    assign gpi_read = gpi_wide[io_addr];
    assign gpo_read = gpo_wide[io_addr];

    // output flip-flops, only the addressed one follows gpo_write
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            gpo <= '0;
        end
        else if (edit_gpo)
        begin
            for (int i = 0; i < number_of_io; i++)
            begin
                if (int'(io_addr) == i)
                begin
                    gpo[i] <= gpo_write;
                end
            end
        end
    end

    // software should only edit bits that exist in this bank
    edit_in_range_a: assert property (
        @(posedge clk) disable iff (!reset)
        edit_gpo |-> in_range
    ) else $error("edit of io bit %0d outside bank of %0d", io_addr, number_of_io);

endmodule

//--- source/reflet_io_pkg.sv
package reflet_io_pkg;

    // system bus geometry
    localparam int bus_addr_size = 16;
    localparam int bus_width = 8;

    // io bit selection, one byte wide
    localparam int io_addr_size = 8;
    localparam int max_io = 2 ** io_addr_size;

    // register offsets inside a bank window
    localparam logic [bus_addr_size-1:0] reg_io_addr = 16'd0;
    localparam logic [bus_addr_size-1:0] reg_io_ctrl = 16'd1;

    // control register bit positions
    localparam int ctrl_gpi_read = 0;
    localparam int ctrl_gpo_read = 1;
    localparam int ctrl_gpo_write = 2;
    localparam int ctrl_edit_gpo = 3;

    // bits 4 to 7 of control always read zero
    localparam logic [bus_width-1:0] ctrl_mask = 8'h0F;

    // one registered bus access
    typedef struct packed {
        logic valid;
        logic [bus_addr_size-1:0] addr;
        logic write_en;
        logic [bus_width-1:0] data;
    } bus_request_t;

    // read data, zero when the access is not ours
    typedef struct packed {
        logic [bus_width-1:0] data;
    } bus_response_t;

endpackage
